//--- verilog.f
+incdir+common
common/hub_pkg.sv
rtl/fifo_fwft.sv
egress/egress_arbiter.sv
egress/flit_serializer.sv
ingress/ingress_dispatch.sv
rtl/arbitration_hub.sv
bench/arbitration_hub_props.sv
bench/arbitration_hub_tb.sv

//--- Makefile
TOP = arbitration_hub_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- bench/arbitration_hub_tb.sv
`timescale 1ns/1ps
`include "hub_consts.svh"

module arbitration_hub_tb;

    localparam int NCASES = 6;
    localparam int NPORTS = `HUB_PORT_COUNT;
    localparam logic [31:0] SEED = 32'hf991;
    localparam logic [31:0] TAPS = 32'h80200003;
    localparam int WATCHDOG_NS = (NCASES * 40 + 10) * 4;

    // one test case: egress loads, link stall, ingress codes, expected port order
    typedef struct {
        logic [4:0] load;
        logic [4:0] again;
        int stall;
        int n_in;
        logic [1:0][7:0] in_dest;
        int n_out;
        logic [5:0][2:0] order;
    } case_t;

    logic clk;
    logic reset;
    logic [`HUB_CHANNEL_COUNT-1:0][`HUB_WORD_WIDTH-1:0] master_out_data;
    logic [`HUB_CHANNEL_COUNT-1:0] master_out_valid;
    logic [`HUB_CHANNEL_COUNT-1:0] master_out_ready;
    logic [`HUB_WORD_WIDTH-1:0] sc_out_data;
    logic sc_out_valid;
    logic sc_out_ready;
    logic [`HUB_FLIT_WIDTH-1:0] final_out_data;
    logic final_out_valid;
    logic final_out_ready;
    logic [`HUB_FLIT_WIDTH-1:0] final_in_data;
    logic final_in_valid;
    logic final_in_ready;
    logic [`HUB_CHANNEL_COUNT-1:0][`HUB_WORD_WIDTH-1:0] master_in_data;
    logic [`HUB_CHANNEL_COUNT-1:0] master_in_valid;
    logic [`HUB_CHANNEL_COUNT-1:0] master_in_ready;
    logic [`HUB_WORD_WIDTH-1:0] sc_in_data;
    logic sc_in_valid;
    logic sc_in_ready;
    logic has_flying_messages;

    case_t cases [NCASES];
    logic [31:0] lfsr_state;
    logic [31:0] out_words [NPORTS][2];
    int offers_left [NPORTS];
    int offer_idx [NPORTS];
    int xfer_cnt [NPORTS];
    logic [7:0] rx_flits [$];
    logic [7:0] tx_flits [$];
    logic [31:0] exp_in_words [$];
    int exp_in_dest [$];
    int hold_wait;
    int stall_xfers;
    int cyc;
    int err_count;
    bit seen_flying;

    arbitration_hub UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? TAPS : 32'h0);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        err_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("error at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    // new random word on an egress port
    task automatic offer_word(input int p);
        logic [31:0] w;
        w = lfsr_bits(32);
        out_words[p][offer_idx[p]] = w;
        offer_idx[p]++;
        if (p < `HUB_CHANNEL_COUNT) begin
            master_out_data[p] = w;
            master_out_valid[p] = 1'b1;
        end else begin
            sc_out_data = w;
            sc_out_valid = 1'b1;
        end
    endtask

    // ingress word as four flits, low flit first
    task automatic load_ingress(input logic [7:0] dest);
        logic [31:0] w;
        logic [31:0] id_bits;
        logic [31:0] pay_bits;
        id_bits = lfsr_bits(4);
        pay_bits = lfsr_bits(20);
        w = {id_bits[3:0], dest, pay_bits[19:0]};
        for (int i = 0; i < 4; i++) begin
            tx_flits.push_back(w[8*i +: 8]);
        end
        // routable codes only, others vanish
        if (dest < `HUB_CHANNEL_COUNT) begin
            exp_in_dest.push_back(int'(dest));
            exp_in_words.push_back(w);
        end else if (dest == 8'hff) begin
            exp_in_dest.push_back(4);
            exp_in_words.push_back(w);
        end
    endtask

    // sample at negedge, drive 1 ns after the next rising edge
    task automatic step_cycle(input int stall);
        logic [4:0] ready_now;
        logic [4:0] valid_now;
        logic [4:0] took;
        logic [4:0] exp_mask;
        logic [31:0] got;
        logic in_took;
        int dest;
        @(negedge clk);
        ready_now = {sc_out_ready, master_out_ready};
        valid_now = {sc_out_valid, master_out_valid};
        took = ready_now & valid_now;
        for (int p = 0; p < NPORTS; p++) begin
            if (took[p]) xfer_cnt[p]++;
        end
        // words handed over while the link is stalled
        if (!final_out_ready) stall_xfers += $countones(took);
        if (final_out_valid && final_out_ready) rx_flits.push_back(final_out_data);
        in_took = final_in_valid && final_in_ready;
        if (has_flying_messages) seen_flying = 1'b1;
        if (master_in_valid != 0 || sc_in_valid) begin
            assert (exp_in_dest.size() > 0)
                else report_mismatch("ingress word delivered where none was expected");
            dest = exp_in_dest[0];
            exp_mask = 5'b1 << dest;
            assert ({sc_in_valid, master_in_valid} == exp_mask)
                else report_mismatch($sformatf("ingress valids %b, expected %b",
                    {sc_in_valid, master_in_valid}, exp_mask));
            got = (dest == 4) ? sc_in_data : master_in_data[dest];
            assert (got == exp_in_words[0])
                else report_mismatch($sformatf("ingress word %h, expected %h",
                    got, exp_in_words[0]));
            if (sc_in_ready) begin
                void'(exp_in_dest.pop_front());
                void'(exp_in_words.pop_front());
                hold_wait = 0;
            end else begin
                hold_wait++;
            end
        end
        @(posedge clk);
        #1;
        for (int p = 0; p < NPORTS; p++) begin
            if (took[p] && offers_left[p] > 0) begin
                offers_left[p]--;
                offer_word(p);
            end else if (took[p] && p < `HUB_CHANNEL_COUNT) begin
                master_out_valid[p] = 1'b0;
            end else if (took[p]) begin
                sc_out_valid = 1'b0;
            end
        end
        cyc++;
        final_out_ready = (cyc >= stall);
        if (in_took) void'(tx_flits.pop_front());
        final_in_valid = (tx_flits.size() > 0);
        final_in_data = (tx_flits.size() > 0) ? tx_flits[0] : 8'h00;
        // destination waits two cycles before taking the word
        master_in_ready = (hold_wait >= 2) ? '1 : '0;
        sc_in_ready = (hold_wait >= 2);
    endtask

    task automatic run_case(input int k);
        case_t tc;
        int guard;
        int p;
        int widx [NPORTS];
        logic [31:0] w;
        tc = cases[k];
        rx_flits.delete();
        stall_xfers = 0;
        seen_flying = 1'b0;
        cyc = 0;
        hold_wait = 0;
        final_out_ready = (tc.stall == 0);
        for (int i = 0; i < NPORTS; i++) begin
            xfer_cnt[i] = 0;
            offer_idx[i] = 0;
            widx[i] = 0;
            offers_left[i] = int'(tc.again[i]);
            if (tc.load[i]) offer_word(i);
        end
        for (int i = 0; i < tc.n_in; i++) begin
            load_ingress(tc.in_dest[i]);
        end
        final_in_valid = (tx_flits.size() > 0);
        final_in_data = (tx_flits.size() > 0) ? tx_flits[0] : 8'h00;
        guard = 0;
        do begin
            step_cycle(tc.stall);
            guard++;
        end while (guard < 300 && ({sc_out_valid, master_out_valid} != 0
            || rx_flits.size() != 4 * tc.n_out || tx_flits.size() != 0
            || exp_in_dest.size() != 0 || has_flying_messages));
        assert (guard < 300)
            else report_failure($sformatf("case %0d never went idle", k));
        for (int i = 0; i < NPORTS; i++) begin
            assert (xfer_cnt[i] == int'(tc.load[i]) + int'(tc.again[i]))
                else report_mismatch($sformatf("case %0d port %0d saw %0d transfers",
                    k, i, xfer_cnt[i]));
        end
        // rebuild words from the link, ascending priority order
        for (int i = 0; i < tc.n_out; i++) begin
            p = int'(tc.order[i]);
            w = {rx_flits[4*i+3], rx_flits[4*i+2], rx_flits[4*i+1], rx_flits[4*i]};
            assert (w == out_words[p][widx[p]])
                else report_mismatch($sformatf("case %0d word %0d is %h, expected %h",
                    k, i, w, out_words[p][widx[p]]));
            widx[p]++;
        end
        // a full fifo holds four words, the serializer one more
        if (tc.n_out > 5) begin
            assert (stall_xfers == `HUB_FIFO_DEPTH / `HUB_FLITS_PER_WORD + 1)
                else report_mismatch($sformatf("case %0d took %0d words on a stalled link",
                    k, stall_xfers));
        end
        if (tc.load != 0 || tc.n_in > 0) begin
            assert (seen_flying)
                else report_mismatch($sformatf("case %0d no flying messages seen", k));
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("error: watchdog expired before the tests finished");
        $display("Checks failed");
        $fatal(1, "watchdog");
    end

    initial begin
        reset = 1'b1;
        master_out_data = '0;
        master_out_valid = '0;
        sc_out_data = '0;
        sc_out_valid = 1'b0;
        final_out_ready = 1'b0;
        final_in_data = '0;
        final_in_valid = 1'b0;
        master_in_ready = '0;
        sc_in_ready = 1'b0;
        lfsr_state = SEED;
        err_count = 0;
        // load, again, stall, n_in, {dest1, dest0}, n_out, order low first
        cases[0] = '{5'b00100, 5'b00000, 0, 1, {8'h00, 8'h01}, 1, 18'o2};
        cases[1] = '{5'b11111, 5'b00000, 0, 1, {8'h00, 8'hff}, 5, 18'o43210};
        cases[2] = '{5'b11111, 5'b00001, 30, 2, {8'h03, 8'h07}, 6, 18'o432100};
        cases[3] = '{5'b10010, 5'b00000, 0, 2, {8'hff, 8'h00}, 2, 18'o41};
        cases[4] = '{5'b00000, 5'b00000, 0, 2, {8'h40, 8'h02}, 0, 18'o0};
        cases[5] = '{5'b01000, 5'b00000, 5, 0, {8'h00, 8'h00}, 1, 18'o3};
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!has_flying_messages && !final_out_valid)
            else report_mismatch("flying flag or link valid high after reset");
        assert (master_in_valid == 0 && !sc_in_valid)
            else report_mismatch("ingress valid high after reset");
        @(posedge clk);
        #1;
        for (int k = 0; k < NCASES; k++) begin
            run_case(k);
        end
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- bench/arbitration_hub_props.sv
`timescale 1ns/1ps
`include "hub_consts.svh"

module arbitration_hub_props (
    input logic                          clk,
    input logic                          reset,
    input logic [`HUB_CHANNEL_COUNT-1:0] master_out_valid,
    input logic [`HUB_CHANNEL_COUNT-1:0] master_out_ready,
    input logic                          sc_out_valid,
    input logic                          sc_out_ready,
    input logic [`HUB_CHANNEL_COUNT-1:0] master_in_valid,
    input logic [`HUB_CHANNEL_COUNT-1:0] master_in_ready,
    input logic                          sc_in_valid,
    input logic                          sc_in_ready
);

    // egress take pulse goes to one source at most
    a_out_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sc_out_ready, master_out_ready}))
        else $error("egress readies are not one-hot");

    // readies only toward a source that offers a word
    a_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (({sc_out_ready, master_out_ready} & ~{sc_out_valid, master_out_valid}) == '0))
        else $error("egress ready raised without valid");

    // one destination per held word
    a_in_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sc_in_valid, master_in_valid}))
        else $error("ingress valids are not one-hot");

    genvar c;
    generate
        for (c = 0; c < `HUB_CHANNEL_COUNT; c = c + 1) begin : g_hold
            a_in_hold: assert property (@(posedge clk) disable iff (reset)
                master_in_valid[c] && !master_in_ready[c] |=> master_in_valid[c])
                else $error("master ingress valid dropped before ready");
        end
    endgenerate

    a_sc_hold: assert property (@(posedge clk) disable iff (reset)
        sc_in_valid && !sc_in_ready |=> sc_in_valid)
        else $error("stage controller ingress valid dropped before ready");

endmodule

bind arbitration_hub arbitration_hub_props props (
    .clk              (clk),
    .reset            (reset),
    .master_out_valid (master_out_valid),
    .master_out_ready (master_out_ready),
    .sc_out_valid     (sc_out_valid),
    .sc_out_ready     (sc_out_ready),
    .master_in_valid  (master_in_valid),
    .master_in_ready  (master_in_ready),
    .sc_in_valid      (sc_in_valid),
    .sc_in_ready      (sc_in_ready)
);

//--- rtl/arbitration_hub.sv
`timescale 1ns/1ps
`include "hub_consts.svh"

module arbitration_hub (
    input  logic                                            clk,
    input  logic                                            reset,
    // egress from channels
    input  logic [`HUB_CHANNEL_COUNT-1:0][`HUB_WORD_WIDTH-1:0] master_out_data,
    input  logic [`HUB_CHANNEL_COUNT-1:0]                   master_out_valid,
    output logic [`HUB_CHANNEL_COUNT-1:0]                   master_out_ready,
    input  logic [`HUB_WORD_WIDTH-1:0]                      sc_out_data,
    input  logic                                            sc_out_valid,
    output logic                                            sc_out_ready,
    // link side
    output logic [`HUB_FLIT_WIDTH-1:0]                      final_out_data,
    output logic                                            final_out_valid,
    input  logic                                            final_out_ready,
    input  logic [`HUB_FLIT_WIDTH-1:0]                      final_in_data,
    input  logic                                            final_in_valid,
    output logic                                            final_in_ready,
    // ingress toward channels
    output logic [`HUB_CHANNEL_COUNT-1:0][`HUB_WORD_WIDTH-1:0] master_in_data,
    output logic [`HUB_CHANNEL_COUNT-1:0]                   master_in_valid,
    input  logic [`HUB_CHANNEL_COUNT-1:0]                   master_in_ready,
    output logic [`HUB_WORD_WIDTH-1:0]                      sc_in_data,
    output logic                                            sc_in_valid,
    input  logic                                            sc_in_ready,
    output logic                                            has_flying_messages
);

    hub_pkg::hub_word_t port_data [`HUB_PORT_COUNT];
    logic [`HUB_PORT_COUNT-1:0] port_valid;
    logic [`HUB_PORT_COUNT-1:0] port_ready;
    hub_pkg::hub_word_t word_data;
    logic word_valid;
    logic word_ready;
    hub_pkg::flit_t ser_flit_data;
    logic ser_flit_valid;
    logic out_full;
    logic out_empty;
    hub_pkg::flit_t in_flit_data;
    logic in_full;
    logic in_empty;
    logic in_pop;
    hub_pkg::hub_word_t in_word;
    logic flying_next;

    genvar c;

    // masters take ports 0..3, stage controller is the last port
    generate
        for (c = 0; c < `HUB_CHANNEL_COUNT; c = c + 1) begin : g_join
            assign port_data[c] = master_out_data[c];
            assign master_in_data[c] = in_word;
        end
    endgenerate

    assign port_data[`HUB_CHANNEL_COUNT] = sc_out_data;
    assign port_valid = {sc_out_valid, master_out_valid};
    assign master_out_ready = port_ready[`HUB_CHANNEL_COUNT-1:0];
    assign sc_out_ready = port_ready[`HUB_CHANNEL_COUNT];
    assign sc_in_data = in_word;

    egress_arbiter arbiter (
        .port_data  (port_data),
        .port_valid (port_valid),
        .word_ready (word_ready),
        .port_ready (port_ready),
        .word_data  (word_data),
        .word_valid (word_valid)
    );

    flit_serializer serializer (
        .clk        (clk),
        .reset      (reset),
        .word_data  (word_data),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .flit_data  (ser_flit_data),
        .flit_valid (ser_flit_valid),
        .flit_full  (out_full)
    );

    // link reads straight from the fall-through head
    fifo_fwft #(.WIDTH(`HUB_FLIT_WIDTH), .DEPTH(`HUB_FIFO_DEPTH)) out_fifo (
        .clk   (clk),
        .reset (reset),
        .wr_en (ser_flit_valid),
        .din   (ser_flit_data),
        .full  (out_full),
        .rd_en (final_out_ready),
        .dout  (final_out_data),
        .empty (out_empty)
    );

    assign final_out_valid = !out_empty;

    fifo_fwft #(.WIDTH(`HUB_FLIT_WIDTH), .DEPTH(`HUB_FIFO_DEPTH)) in_fifo (
        .clk   (clk),
        .reset (reset),
        .wr_en (final_in_valid),
        .din   (final_in_data),
        .full  (in_full),
        .rd_en (in_pop),
        .dout  (in_flit_data),
        .empty (in_empty)
    );

    assign final_in_ready = !in_full;

    ingress_dispatch dispatch (
        .clk        (clk),
        .reset      (reset),
        .flit_data  (in_flit_data),
        .flit_empty (in_empty),
        .flit_pop   (in_pop),
        .chan_data  (in_word),
        .chan_valid (master_in_valid),
        .chan_ready (master_in_ready),
        .sc_valid   (sc_in_valid),
        .sc_ready   (sc_in_ready)
    );

    // in-flight traffic anywhere, external valids included
    // held word shows up as the ingress valids
    assign flying_next = (|master_out_valid) || sc_out_valid
        || final_out_valid || final_in_valid
        || (|master_in_valid) || sc_in_valid
        || word_valid || ser_flit_valid || !in_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            has_flying_messages <= 1'b0;
        end else begin
            has_flying_messages <= flying_next;
        end
    end

endmodule

//--- ingress/ingress_dispatch.sv
`timescale 1ns/1ps
`include "hub_consts.svh"

module ingress_dispatch (
    input  logic                            clk,
    input  logic                            reset,
    input  hub_pkg::flit_t                  flit_data,
    input  logic                            flit_empty,
    output logic                            flit_pop,
    output hub_pkg::hub_word_t              chan_data,
    output logic [`HUB_CHANNEL_COUNT-1:0]   chan_valid,
    input  logic [`HUB_CHANNEL_COUNT-1:0]   chan_ready,
    output logic                            sc_valid,
    input  logic                            sc_ready
);

    localparam int CW = $clog2(`HUB_FLITS_PER_WORD);

    hub_pkg::des_state_t state;
    logic [CW-1:0] flit_cnt;
    logic [`HUB_WORD_WIDTH-1:0] asm_word;
    hub_pkg::hub_word_t held_word;
    logic holding;
    logic [`HUB_CHANNEL_COUNT-1:0] chan_match;
    logic is_master;
    logic is_sc;
    logic master_ready;
    logic hold_done;

    assign holding = (state == hub_pkg::DES_HOLD);

    // one flit per cycle while collecting
    assign flit_pop = (state == hub_pkg::DES_COLLECT) && !flit_empty;

    assign held_word = hub_pkg::hub_word_t'(asm_word);

    // same word on every channel, valid picks the receiver
    assign chan_data = held_word;

    // destination decode
    always_comb begin
        chan_match = '0;
        master_ready = 1'b0;
        for (int c = 0; c < `HUB_CHANNEL_COUNT; c++) begin
            if (held_word.dest_channel == `HUB_CHANNEL_ID_WIDTH'(c)) begin
                chan_match[c] = 1'b1;
                master_ready = chan_ready[c];
            end
        end
    end

    assign is_master = |chan_match;
    assign is_sc = (held_word.dest_channel == `HUB_STAGE_CTRL_ID);

    assign chan_valid = holding ? chan_match : '0;
    assign sc_valid = holding && is_sc;

    // unknown codes finish at once, so the word is dropped
    always_comb begin
        if (is_sc) begin
            hold_done = sc_ready;
        end else if (is_master) begin
            hold_done = master_ready;
        end else begin
            hold_done = 1'b1;
        end
    end

    // first flit ends up lowest, new flits enter at the top
    always_ff @(posedge clk) begin
        if (flit_pop) begin
            asm_word <= {flit_data, asm_word[`HUB_WORD_WIDTH-1:`HUB_FLIT_WIDTH]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hub_pkg::DES_COLLECT;
            flit_cnt <= '0;
        end else begin
            case (state)
                hub_pkg::DES_COLLECT: begin
                    if (flit_pop) begin
                        flit_cnt <= flit_cnt + 1'b1;
                        if (flit_cnt == CW'(`HUB_FLITS_PER_WORD - 1)) begin
                            state <= hub_pkg::DES_HOLD;
                            flit_cnt <= '0;
                        end
                    end
                end
                hub_pkg::DES_HOLD: begin
                    if (hold_done) begin
                        state <= hub_pkg::DES_COLLECT;
                    end
                end
                default: state <= hub_pkg::DES_COLLECT;
            endcase
        end
    end

endmodule

//--- egress/flit_serializer.sv
`timescale 1ns/1ps
`include "hub_consts.svh"

module flit_serializer (
    input  logic               clk,
    input  logic               reset,
    input  hub_pkg::hub_word_t word_data,
    input  logic               word_valid,
    output logic               word_ready,
    output hub_pkg::flit_t     flit_data,
    output logic               flit_valid,
    input  logic               flit_full
);

    localparam int CW = $clog2(`HUB_FLITS_PER_WORD);

    hub_pkg::ser_state_t state;
    logic [`HUB_WORD_WIDTH-1:0] shift_reg;
    logic [CW-1:0] flit_cnt;
    logic last_flit;
    logic take_word;

    assign last_flit = (flit_cnt == CW'(`HUB_FLITS_PER_WORD - 1));

    // stall while the output fifo is full
    assign flit_valid = (state == hub_pkg::SER_SHIFT) && !flit_full;

    // low flit always sits at the bottom of the shifter
    assign flit_data = shift_reg[`HUB_FLIT_WIDTH-1:0];

    // free when idle, or in the cycle the last flit goes out
    assign word_ready = (state == hub_pkg::SER_IDLE) || (flit_valid && last_flit);
    assign take_word = word_ready && word_valid;

    // word payload, no reset needed
    always_ff @(posedge clk) begin
        if (take_word) begin
            shift_reg <= word_data;
        end else if (flit_valid) begin
            shift_reg <= shift_reg >> `HUB_FLIT_WIDTH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hub_pkg::SER_IDLE;
            flit_cnt <= '0;
        end else begin
            if (take_word) begin
                // back to back words skip the idle state
                state <= hub_pkg::SER_SHIFT;
                flit_cnt <= '0;
            end else if (flit_valid) begin
                flit_cnt <= flit_cnt + 1'b1;
                if (last_flit) begin
                    state <= hub_pkg::SER_IDLE;
                end
            end
        end
    end

endmodule

//--- egress/egress_arbiter.sv
`timescale 1ns/1ps
`include "hub_consts.svh"

module egress_arbiter (
    input  hub_pkg::hub_word_t              port_data [`HUB_PORT_COUNT],
    input  logic [`HUB_PORT_COUNT-1:0]      port_valid,
    input  logic                            word_ready,
    output logic [`HUB_PORT_COUNT-1:0]      port_ready,
    output hub_pkg::hub_word_t              word_data,
    output logic                            word_valid
);

    // tree sizing, leaves padded up to a power of two
    localparam int DEPTH = $clog2(`HUB_PORT_COUNT);
    localparam int LEAVES = 2 ** DEPTH;
    localparam int NODES = 2 * LEAVES - 1;
    localparam int ROOT = NODES - 1;

    // flattened tree, leaves first, root last
    logic node_valid [NODES];
    hub_pkg::port_index_t node_index [NODES];
    hub_pkg::hub_word_t node_data [NODES];

    genvar i;
    genvar j;

    generate
        // leaves, unused ones never win
        for (i = 0; i < LEAVES; i = i + 1) begin : g_leaf
            if (i < `HUB_PORT_COUNT) begin : g_used
                assign node_valid[i] = port_valid[i];
                assign node_index[i] = hub_pkg::port_index_t'(i);
                assign node_data[i] = port_data[i];
            end else begin : g_pad
                assign node_valid[i] = 1'b0;
                assign node_index[i] = '0;
                assign node_data[i] = '0;
            end
        end

        // pairwise elections, left child (lower index) has priority
        for (i = 0; i < DEPTH; i = i + 1) begin : g_layer
            localparam int WIDTH = 2 ** (DEPTH - 1 - i);
            localparam int BASE = 2 ** (DEPTH + 1) - 2 ** (DEPTH - i);
            localparam int PREV = 2 ** (DEPTH + 1) - 2 ** (DEPTH + 1 - i);
            for (j = 0; j < WIDTH; j = j + 1) begin : g_node
                localparam int CUR = BASE + j;
                localparam int LEFT = PREV + 2 * j;
                localparam int RIGHT = LEFT + 1;
                assign node_valid[CUR] = node_valid[LEFT] | node_valid[RIGHT];
                assign node_index[CUR] = node_valid[LEFT] ? node_index[LEFT] : node_index[RIGHT];
                assign node_data[CUR] = node_valid[LEFT] ? node_data[LEFT] : node_data[RIGHT];
            end
        end

        // one-hot take pulse, only when the serializer can accept
        for (i = 0; i < `HUB_PORT_COUNT; i = i + 1) begin : g_ready
            assign port_ready[i] = node_valid[ROOT] && word_ready
                && (node_index[ROOT] == hub_pkg::port_index_t'(i));
        end
    endgenerate

    assign word_valid = node_valid[ROOT];
    assign word_data = node_data[ROOT];

endmodule

//--- rtl/fifo_fwft.sv
`timescale 1ns/1ps

module fifo_fwft #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_write;
    logic do_read;

    // requests are ignored when they cannot be served
    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    assign full = (count == CW'(DEPTH));
    assign empty = (count == '0);

    // head entry falls through while not empty
    assign dout = mem[rd_ptr];

    // storage itself
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap explicitly so depth need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy unchanged
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- common/hub_pkg.sv
`include "hub_consts.svh"

package hub_pkg;

    // word layout, fpga id on top, then destination, then payload
    typedef struct packed {
        logic [`HUB_FPGA_ID_WIDTH-1:0] fpga_id;
        logic [`HUB_CHANNEL_ID_WIDTH-1:0] dest_channel;
        logic [`HUB_WORD_WIDTH-`HUB_FPGA_ID_WIDTH-`HUB_CHANNEL_ID_WIDTH-1:0] payload;
    } hub_word_t;

    // one link flit
    typedef logic [`HUB_FLIT_WIDTH-1:0] flit_t;

    // winner index, 0..3 masters, 4 stage controller
    typedef logic [2:0] port_index_t;

    // serializer states
    typedef enum logic {
        SER_IDLE,
        SER_SHIFT
    } ser_state_t;

    // dispatcher states
    typedef enum logic {
        DES_COLLECT,
        DES_HOLD
    } des_state_t;

endpackage

//--- common/hub_consts.svh
`ifndef HUB_CONSTS_SVH
`define HUB_CONSTS_SVH

// channel word and link flit widths
`define HUB_WORD_WIDTH 32
`define HUB_FLIT_WIDTH 8
`define HUB_FLITS_PER_WORD 4

// four master channels, stage controller is the extra port
`define HUB_CHANNEL_COUNT 4
`define HUB_PORT_COUNT 5

// flit entries in each link fifo
`define HUB_FIFO_DEPTH 16

// header fields at the top of a word
`define HUB_FPGA_ID_WIDTH 4
`define HUB_CHANNEL_ID_WIDTH 8

// all ones selects the stage controller
`define HUB_STAGE_CTRL_ID {`HUB_CHANNEL_ID_WIDTH{1'b1}}

`endif
